// File: src/hb_pkg.sv
//////////////////////////////////////////////////
// host-bus side types
// address and data widths of the host port
//////////////////////////////////////////////////
`default_nettype none

package hb_pkg;

  localparam int HB_WIDTH = 32;

  typedef logic [HB_WIDTH-1:0] hb_addr_t;  // host byte address
  typedef logic [HB_WIDTH-1:0] hb_data_t;  // host write / read data

endpackage

`default_nettype wire

// File: src/wb_pkg.sv
//////////////////////////////////////////////////
// wishbone side types for the 8-bit port
// master state encoding, shared with the checker
//////////////////////////////////////////////////
`default_nettype none

package wb_pkg;

  localparam int WB_WIDTH = 8;

  typedef logic [WB_WIDTH-1:0] wb_adr_t;  // low byte of host address
  typedef logic [WB_WIDTH-1:0] wb_dat_t;

  // one transaction at a time, no pipelining
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    CYCLE = 2'd1,
    DONE  = 2'd2
  } master_state_t;

endpackage

`default_nettype wire

// File: src/wb_cycle_timer.sv
//////////////////////////////////////////////////
// wishbone cycle timeout counter
// single expire pulse when a cycle runs too long
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module wb_cycle_timer #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic cyc_active_i,
  output logic expire_o
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(TIMEOUT_CYCLES - 1);

  logic [CNT_W-1:0] count;

  // count parks one past the limit so expire fires only once
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !cyc_active_i) begin
      count <= '0;
    end else if (count <= LIMIT) begin
      count <= count + 1'b1;
    end
  end

  assign expire_o = cyc_active_i && (count == LIMIT);

endmodule

`default_nettype wire

// File: src/wb_reg_slave.sv
//////////////////////////////////////////////////
// 8-bit wishbone register bank slave
// fixed wait states before ack
// unmapped addresses are never acked
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module wb_reg_slave #(
  parameter int NUM_REGS    = 16,
  parameter int WAIT_STATES = 2
) (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  wb_pkg::wb_adr_t wb_adr_i,
  input  wb_pkg::wb_dat_t wb_dat_i,
  output wb_pkg::wb_dat_t wb_dat_o,
  output logic            wb_ack_o
);

  localparam int IDX_W  = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;
  localparam int WAIT_W = $clog2(WAIT_STATES + 2);
  localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(WAIT_STATES);

  wb_pkg::wb_dat_t   regs [NUM_REGS];
  logic [WAIT_W-1:0] wait_cnt;
  logic [IDX_W-1:0]  reg_idx;
  logic              in_range;
  logic              req;      // live request not yet acked
  logic              hit;      // edge that raises ack

  assign reg_idx  = wb_adr_i[IDX_W-1:0];
  assign in_range = (int'(wb_adr_i) < NUM_REGS);
  assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign hit      = req && in_range && (wait_cnt == WAIT_LAST);

  // wait states, saturate so an unmapped cycle just sits
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !req) begin
      wait_cnt <= '0;
    end else if (wait_cnt != WAIT_LAST) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= hit;  // single cycle, req drops while ack is high
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (hit && wb_we_i) begin
      regs[reg_idx] <= wb_dat_i;
    end
  end

  // read data lines up with ack
  always_ff @(posedge wb_clk_i) begin
    if (hit && !wb_we_i) begin
      wb_dat_o <= regs[reg_idx];
    end
  end

endmodule

`default_nettype wire

// File: src/wb_master_fsm.sv
//////////////////////////////////////////////////
// wishbone master FSM
// host strobe in, single classic cycle out,
// read data / error returned with a done pulse
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module wb_master_fsm (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,

  // host side
  input  logic              hb_ren_i,
  input  logic              hb_wen_i,
  input  hb_pkg::hb_addr_t  hb_addr_i,
  input  hb_pkg::hb_data_t  hb_wdata_i,
  output hb_pkg::hb_data_t  hb_rdata_o,
  output logic              hb_busy_o,
  output logic              hb_done_o,
  output logic              hb_err_o,

  // wishbone side
  input  logic              wb_ack_i,
  input  wb_pkg::wb_dat_t   wb_dat_i,
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output wb_pkg::wb_adr_t   wb_adr_o,
  output wb_pkg::wb_dat_t   wb_dat_o,

  // from cycle timer
  input  logic              expire_i
);

  localparam int PAD_W = $bits(hb_pkg::hb_data_t) - $bits(wb_pkg::wb_dat_t);

  wb_pkg::master_state_t state;
  logic                  start;    // accepted strobe
  logic                  cyc_end;  // ack or timeout closes the cycle

  assign start   = (state == wb_pkg::IDLE) && (hb_ren_i || hb_wen_i);
  assign cyc_end = (state == wb_pkg::CYCLE) && (wb_ack_i || expire_i);

  assign hb_busy_o = (state != wb_pkg::IDLE);
  assign hb_done_o = (state == wb_pkg::DONE);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state      <= wb_pkg::IDLE;
      wb_cyc_o   <= 1'b0;
      wb_stb_o   <= 1'b0;
      wb_we_o    <= 1'b0;
      hb_err_o   <= 1'b0;
      hb_rdata_o <= '0;
    end else begin
      case (state)
        wb_pkg::IDLE: begin
          if (start) begin
            state    <= wb_pkg::CYCLE;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
            wb_we_o  <= !hb_ren_i;  // read wins over write
          end
        end
        wb_pkg::CYCLE: begin
          if (cyc_end) begin
            state    <= wb_pkg::DONE;
            wb_cyc_o <= 1'b0;
            wb_stb_o <= 1'b0;
            hb_err_o <= !wb_ack_i;  // ack takes priority over a late expire
            if (wb_ack_i && !wb_we_o) begin
              hb_rdata_o <= {{PAD_W{1'b0}}, wb_dat_i};
            end
          end
        end
        wb_pkg::DONE: begin
          state    <= wb_pkg::IDLE;
          hb_err_o <= 1'b0;  // error only valid alongside done
        end
        default: begin
          state <= wb_pkg::IDLE;
        end
      endcase
    end
  end

  // address and write byte, latched on accept
  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      wb_adr_o <= hb_addr_i[$bits(wb_pkg::wb_adr_t)-1:0];
      wb_dat_o <= hb_wdata_i[$bits(wb_pkg::wb_dat_t)-1:0];
    end
  end

endmodule

`default_nettype wire

// File: src/hb_wb_bridge_top.sv
//////////////////////////////////////////////////
// host-bus to 8-bit wishbone bridge, top level
// master FSM, cycle timer and register slave
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module hb_wb_bridge_top #(
  parameter int NUM_REGS       = 16,
  parameter int WAIT_STATES    = 2,
  parameter int TIMEOUT_CYCLES = 16  // must exceed WAIT_STATES+2
) (
  input  logic             wb_clk_i,
  input  logic             wb_rst_i,
  input  logic             hb_ren_i,
  input  logic             hb_wen_i,
  input  hb_pkg::hb_addr_t hb_addr_i,
  input  hb_pkg::hb_data_t hb_wdata_i,
  output hb_pkg::hb_data_t hb_rdata_o,
  output logic             hb_busy_o,
  output logic             hb_done_o,
  output logic             hb_err_o
);

  // internal wishbone bus
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  wb_pkg::wb_adr_t wb_adr;
  wb_pkg::wb_dat_t wb_dat_w;
  wb_pkg::wb_dat_t wb_dat_r;
  logic            wb_ack;
  logic            expire;   // timeout from the timer

  wb_master_fsm u_master (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .hb_ren_i   (hb_ren_i),
    .hb_wen_i   (hb_wen_i),
    .hb_addr_i  (hb_addr_i),
    .hb_wdata_i (hb_wdata_i),
    .hb_rdata_o (hb_rdata_o),
    .hb_busy_o  (hb_busy_o),
    .hb_done_o  (hb_done_o),
    .hb_err_o   (hb_err_o),
    .wb_ack_i   (wb_ack),
    .wb_dat_i   (wb_dat_r),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_we_o    (wb_we),
    .wb_adr_o   (wb_adr),
    .wb_dat_o   (wb_dat_w),
    .expire_i   (expire)
  );

  wb_cycle_timer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_timer (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .cyc_active_i (wb_cyc),
    .expire_o     (expire)
  );

  wb_reg_slave #(
    .NUM_REGS    (NUM_REGS),
    .WAIT_STATES (WAIT_STATES)
  ) u_slave (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

endmodule

`default_nettype wire

// File: bench/wb_bus_checker.sv
//////////////////////////////////////////////////
// wishbone protocol assertions for the bridge
// bound into hb_wb_bridge_top
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module wb_bus_checker #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input logic                  wb_clk_i,
  input logic                  wb_rst_i,
  input logic                  wb_cyc_i,
  input logic                  wb_stb_i,
  input logic                  wb_ack_i,
  input logic                  hb_done_i,
  input wb_pkg::master_state_t state_i
);

  int open_cnt;  // edges seen with the current cycle open

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !wb_cyc_i) begin
      open_cnt <= 0;
    end else begin
      open_cnt <= open_cnt + 1;
    end
  end

  stb_needs_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_stb_i |-> wb_cyc_i)
    else $error("wb_stb high without wb_cyc");

  ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_i |-> wb_stb_i)
    else $error("wb_ack high without wb_stb");

  // timer must close any cycle, acked or not
  cycle_closes: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_cyc_i |-> (open_cnt <= TIMEOUT_CYCLES))
    else $error("wishbone cycle open for more than %0d cycles", TIMEOUT_CYCLES + 1);

  done_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    hb_done_i |=> !hb_done_i)
    else $error("hb_done_o wider than one cycle");

  // slave ack must close the master's cycle on the next edge
  ack_ends_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ((state_i == wb_pkg::CYCLE) && wb_ack_i) |=> ((state_i == wb_pkg::DONE) && !wb_cyc_i))
    else $error("wb_ack seen in CYCLE but the master did not close the cycle");

endmodule

bind hb_wb_bridge_top wb_bus_checker #(
  .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
) u_bus_checker (
  .wb_clk_i  (wb_clk_i),
  .wb_rst_i  (wb_rst_i),
  .wb_cyc_i  (wb_cyc),
  .wb_stb_i  (wb_stb),
  .wb_ack_i  (wb_ack),
  .hb_done_i (hb_done_o),
  .state_i   (u_master.state)
);

`default_nettype wire

// File: bench/tb_hb_wb.sv
//////////////////////////////////////////////////
// testbench for the host-bus to wishbone bridge
// random accesses checked against a register model
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_hb_wb;

  localparam int NUM_REGS       = 16;
  localparam int WAIT_STATES    = 2;
  localparam int TIMEOUT_CYCLES = 16;
  localparam int CLK_PERIOD     = 4;
  localparam int N_WRITES       = 32;
  localparam int N_UNMAPPED     = 16;
  localparam int N_PROBES       = 4;
  localparam int N_RANDOM       = 300;
  localparam int TOTAL_OPS      = 4 * NUM_REGS + N_WRITES + N_UNMAPPED + 2 * N_PROBES + N_RANDOM;
  localparam int WATCHDOG_NS    = (TOTAL_OPS * (TIMEOUT_CYCLES + 4) + 200) * CLK_PERIOD;

  logic             wb_clk_i;
  logic             wb_rst_i;
  logic             hb_ren_i;
  logic             hb_wen_i;
  hb_pkg::hb_addr_t hb_addr_i;
  hb_pkg::hb_data_t hb_wdata_i;
  hb_pkg::hb_data_t hb_rdata_o;
  logic             hb_busy_o;
  logic             hb_done_o;
  logic             hb_err_o;

  integer      seed = 32'h792a;
  logic [7:0]  model [NUM_REGS];  // expected register bank
  logic [31:0] exp_rdata;         // held until the next good read

  hb_wb_bridge_top #(
    .NUM_REGS       (NUM_REGS),
    .WAIT_STATES    (WAIT_STATES),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) DUT (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .hb_ren_i   (hb_ren_i),
    .hb_wen_i   (hb_wen_i),
    .hb_addr_i  (hb_addr_i),
    .hb_wdata_i (hb_wdata_i),
    .hb_rdata_o (hb_rdata_o),
    .hb_busy_o  (hb_busy_o),
    .hb_done_o  (hb_done_o),
    .hb_err_o   (hb_err_o)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
    $display("Test FAILED");
    $fatal(1, "watchdog timeout");
  end

  task automatic tick();
    @(posedge wb_clk_i);
    #1;  // drive and sample away from the edge
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // random upper bits, only the low byte reaches the bus
  function automatic logic [31:0] rand_addr(input logic [7:0] lo);
    logic [31:0] r;
    r = $random(seed);
    return {r[31:8], lo};
  endfunction

  function automatic logic [7:0] mapped_lo();
    return 8'({$random(seed)} % NUM_REGS);
  endfunction

  function automatic logic [7:0] unmapped_lo();
    return 8'(NUM_REGS + {$random(seed)} % (256 - NUM_REGS));
  endfunction

  // one strobe, wait for done, compare with the model
  task automatic access(input logic ren, input logic wen, input logic [7:0] lo);
    logic [31:0] wdata;
    int          waited;
    int          idx;
    logic        mapped;
    wdata      = $random(seed);
    idx        = int'(lo);
    mapped     = (idx < NUM_REGS);
    hb_ren_i   = ren;
    hb_wen_i   = wen;
    hb_addr_i  = rand_addr(lo);
    hb_wdata_i = wdata;
    tick();
    hb_ren_i = 1'b0;
    hb_wen_i = 1'b0;
    waited   = 0;
    while (hb_done_o !== 1'b1) begin
      if (waited > TIMEOUT_CYCLES + 4) begin
        $display("no hb_done_o within %0d cycles of an accepted strobe", waited);
        $display("Test FAILED");
        $fatal(1, "transaction timeout");
      end
      tick();
      waited++;
    end
    if (mapped && ren) begin
      exp_rdata = {24'h0, model[idx]};  // read wins when both strobes are high
    end else if (mapped) begin
      model[idx] = wdata[7:0];
    end
    check("hb_err_o", 32'(hb_err_o), 32'(!mapped));
    check("hb_rdata_o", hb_rdata_o, exp_rdata);
    tick();
    check("hb_done_o", 32'(hb_done_o), 32'h0);
    check("hb_busy_o", 32'(hb_busy_o), 32'h0);
  endtask

  // a write strobe raised mid-read must be dropped
  task automatic busy_probe();
    logic [7:0] rd_lo;
    int         dones;
    rd_lo     = mapped_lo();
    hb_ren_i  = 1'b1;
    hb_addr_i = rand_addr(rd_lo);
    tick();
    hb_ren_i = 1'b0;
    check("hb_busy_o", 32'(hb_busy_o), 32'h1);
    hb_wen_i   = 1'b1;
    hb_addr_i  = rand_addr(mapped_lo());
    hb_wdata_i = $random(seed);
    dones      = 0;
    repeat (TIMEOUT_CYCLES + 6) begin
      tick();
      hb_wen_i = 1'b0;
      if (hb_done_o === 1'b1) begin
        dones++;
        exp_rdata = {24'h0, model[int'(rd_lo)]};
        check("hb_rdata_o", hb_rdata_o, exp_rdata);
        check("hb_err_o", 32'(hb_err_o), 32'h0);
      end
    end
    check("hb_done_o count", 32'(dones), 32'h1);
    check("hb_busy_o", 32'(hb_busy_o), 32'h0);
  endtask

  initial begin
    logic [2:0] kind;
    logic [1:0] sel;
    logic [7:0] lo;
    wb_rst_i   = 1'b1;
    hb_ren_i   = 1'b0;
    hb_wen_i   = 1'b0;
    hb_addr_i  = '0;
    hb_wdata_i = '0;
    exp_rdata  = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = 8'h00;
    end
    repeat (2) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;

    check("hb_busy_o", 32'(hb_busy_o), 32'h0);
    check("hb_done_o", 32'(hb_done_o), 32'h0);
    check("hb_rdata_o", hb_rdata_o, 32'h0);
    for (int i = 0; i < NUM_REGS; i++) access(1'b1, 1'b0, 8'(i));

    repeat (N_WRITES) access(1'b0, 1'b1, mapped_lo());
    for (int i = 0; i < NUM_REGS; i++) access(1'b1, 1'b0, 8'(i));

    // unmapped cycles end on the timer
    repeat (N_UNMAPPED / 2) begin
      access(1'b0, 1'b1, unmapped_lo());
      access(1'b1, 1'b0, unmapped_lo());
    end
    for (int i = 0; i < NUM_REGS; i++) access(1'b1, 1'b0, 8'(i));

    repeat (N_PROBES) busy_probe();
    for (int i = 0; i < NUM_REGS; i++) access(1'b1, 1'b0, 8'(i));

    repeat (N_RANDOM) begin
      kind = 3'($random(seed));
      sel  = 2'($random(seed));
      lo   = (sel == 2'd0) ? unmapped_lo() : mapped_lo();
      access((kind < 3'd4) || (kind == 3'd7), kind >= 3'd4, lo);  // 7 drives both
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
src/hb_pkg.sv
src/wb_pkg.sv
src/wb_cycle_timer.sv
src/wb_reg_slave.sv
src/wb_master_fsm.sv
src/hb_wb_bridge_top.sv
bench/wb_bus_checker.sv
bench/tb_hb_wb.sv

// File: Makefile
TOP := tb_hb_wb
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Test FAILED (simulator exit status)" >> $(LOG)
	cat $(LOG)
	@! grep -q "Test FAILED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
